// ==== build.f ====
+incdir+design
design/riscv_pkg.sv
design/riscv_stage_if.sv
design/riscv_decode.sv
design/riscv_execute.sv
design/riscv_writeback.sv
design/riscv_core.sv
sim/riscv_props.sv
sim/tb_riscv.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_riscv -o tb_riscv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_riscv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "Result: PASSED" sim.log || exit 1
exit 0

// ==== sim/tb_riscv.sv ====
//////////////////////////////////////////////////
// Programs are assembled in place; 64-word ROM and data memory
// Every store is compared in order with an expected list
//////////////////////////////////////////////////

module tb_riscv;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_IMM   = 7'h13;
    localparam logic [6:0] OP_LOAD  = 7'h03;
    localparam logic [31:0] ECALL   = 32'h0000_0073;
    localparam int NTESTS = 6;

    logic        clk;
    logic        resetb;
    logic [31:0] imem_addr;
    logic        imem_ready;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic        dmem_rready;
    logic [31:0] dmem_raddr;
    logic        dmem_rvalid;
    logic [31:0] dmem_rdata;
    logic        dmem_wready;
    logic [31:0] dmem_waddr;
    logic [31:0] dmem_wdata;
    logic        dmem_wvalid;
    logic        exception;

    logic [31:0] rom [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lcg;
    int          ptr;
    int          st_addr;
    int          rwait;
    int          wwait;
    int          test_err;
    int          n_pass;
    int          n_fail;

    riscv_core u_dut (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Encoders and program helpers
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // Preload depends on the whole word index
    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int next_delay();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return {30'b0, lcg[17:16]};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[ptr] = w;
        ptr++;
    endtask

    task automatic store_exp(input logic [4:0] rs2, input logic [4:0] rs1,
                             input logic [11:0] off, input logic [31:0] addr,
                             input logic [31:0] data);
        emit(enc_s(off, rs2, rs1));
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_next(input logic [4:0] rs2, input logic [31:0] data);
        store_exp(rs2, 5'd0, st_addr[11:0], st_addr, data);
        st_addr += 4;
    endtask

    // Slots after a taken branch must never store
    task automatic emit_bad_slots();
        emit(enc_s(12'hfc, 5'd10, 5'd0));
        emit(enc_s(12'hfc, 5'd10, 5'd0));
    endtask

    task automatic branch_taken(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        emit(enc_b(13'd12, rs2, rs1, f3));
        emit_bad_slots();
        store_next(5'd10, 32'h55);
    endtask

    task automatic branch_not(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2);
        emit(enc_b(13'd8, rs2, rs1, f3));
        store_next(5'd10, 32'h55);
    endtask

    //////////////////////////////////////////////////
    // Programs
    task automatic load_program(input int t);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        ptr = 0;
        st_addr = 32'h80;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 64; i++) begin
            rom[i]  = enc_j(21'd0, 5'd0);   // Self loop
            dmem[i] = fill_word(i);
        end
        a = 32'hffff_fb2e;                  // -1234
        b = 32'h0000_0123;
        case (t)
            1: begin
                emit(enc_i(12'hb2e, 5'd0, 3'b000, 5'd1, OP_IMM));
                emit(enc_i(12'h123, 5'd0, 3'b000, 5'd2, OP_IMM));
                store_next(5'd1, a);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
                emit(enc_i(12'd100, 5'd3, 3'b000, 5'd13, OP_IMM));
                store_next(5'd3, a + b);
                store_next(5'd13, a + b + 32'd100);
                emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
                store_next(5'd4, a - b);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
                store_next(5'd5, a ^ b);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
                store_next(5'd6, a | b);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
                store_next(5'd7, a & b);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
                store_next(5'd8, {31'b0, $signed(a) < $signed(b)});
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd9));
                store_next(5'd9, {31'b0, a < b});
                emit(enc_r(7'h00, 5'd1, 5'd2, 3'b001, 5'd10));
                store_next(5'd10, b << a[4:0]);
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd11));
                store_next(5'd11, a >> b[4:0]);
                emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd12));
                store_next(5'd12, $signed(a) >>> b[4:0]);
            end
            2: begin
                emit(enc_u(20'h12345, 5'd1, OP_LUI));
                store_next(5'd1, 32'h1234_5000);
                p = ptr * 4;
                emit(enc_u(20'habcde, 5'd2, OP_AUIPC));
                store_next(5'd2, p + 32'habcd_e000);
            end
            3: begin
                emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
                emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OP_IMM));   // -3
                emit(enc_i(12'd5, 5'd0, 3'b000, 5'd3, OP_IMM));
                emit(enc_i(12'h055, 5'd0, 3'b000, 5'd10, OP_IMM));
                branch_taken(3'b000, 5'd1, 5'd3);
                branch_taken(3'b001, 5'd1, 5'd2);
                branch_taken(3'b100, 5'd2, 5'd1);
                branch_taken(3'b101, 5'd1, 5'd2);
                branch_taken(3'b110, 5'd1, 5'd2);
                branch_taken(3'b111, 5'd2, 5'd1);
                branch_not(3'b000, 5'd1, 5'd2);
                branch_not(3'b001, 5'd1, 5'd3);
                branch_not(3'b100, 5'd1, 5'd2);
                branch_not(3'b101, 5'd2, 5'd1);
                branch_not(3'b110, 5'd2, 5'd1);
                branch_not(3'b111, 5'd1, 5'd2);
                p = ptr * 4;
                emit(enc_j(21'd12, 5'd5));
                emit_bad_slots();
                store_next(5'd5, p + 32'd4);
                p = ptr * 4;
                emit(enc_u(20'h0, 5'd6, OP_AUIPC));
                emit(enc_i(12'd16, 5'd6, 3'b000, 5'd7, OP_JALR));
                emit_bad_slots();
                store_next(5'd7, p + 32'd8);
            end
            4: begin
                emit(enc_i(12'h020, 5'd0, 3'b000, 5'd3, OP_IMM));
                emit(enc_i(12'h040, 5'd0, 3'b010, 5'd1, OP_LOAD));
                emit(enc_i(12'd1, 5'd1, 3'b000, 5'd1, OP_IMM));
                store_exp(5'd1, 5'd0, 12'h044, 32'h44, fill_word(16) + 32'd1);
                emit(enc_i(12'h044, 5'd0, 3'b010, 5'd2, OP_LOAD));
                emit(enc_i(12'd1, 5'd2, 3'b000, 5'd2, OP_IMM));
                store_exp(5'd2, 5'd0, 12'h048, 32'h48, fill_word(16) + 32'd2);
                emit(enc_i(12'd8, 5'd3, 3'b010, 5'd4, OP_LOAD));
                emit(enc_i(12'd1, 5'd4, 3'b000, 5'd4, OP_IMM));
                store_exp(5'd4, 5'd3, 12'd4, 32'h24, fill_word(10) + 32'd1);
                emit(enc_i(12'd4, 5'd3, 3'b010, 5'd5, OP_LOAD));
                store_exp(5'd5, 5'd0, 12'h04c, 32'h4c, fill_word(10) + 32'd1);
            end
            5: begin
                emit(enc_i(12'h077, 5'd0, 3'b000, 5'd1, OP_IMM));
                store_exp(5'd1, 5'd0, 12'h010, 32'h10, 32'h77);
                emit(ECALL);
            end
            default: begin
                // JALR target 0x1a has bit 1 set
                emit(enc_i(12'h01a, 5'd0, 3'b000, 5'd1, OP_IMM));
                store_exp(5'd1, 5'd0, 12'h010, 32'h10, 32'h1a);
                emit(enc_i(12'd0, 5'd1, 3'b000, 5'd0, OP_JALR));
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // ROM and data memory models
    always @(posedge clk) begin
        if (imem_ready)
            imem_rdata <= rom[imem_addr[7:2]];
    end

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (exception) begin
            $display("exception set before the faulting instruction at %0t", $time);
            test_err++;
        end
        if (exp_addr.size() == 0) begin
            $display("unexpected store to %h at %0t", addr, $time);
            test_err++;
        end else begin
            if (addr !== exp_addr[0]) begin
                $display("ERR %0t dmem_waddr expected %h got %h", $time, exp_addr[0], addr);
                test_err++;
            end
            if (data !== exp_data[0]) begin
                $display("ERR %0t dmem_wdata expected %h got %h", $time, exp_data[0], data);
                test_err++;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    endtask

    always @(posedge clk) begin
        if (!resetb) begin
            dmem_rvalid <= 1'b0;
            dmem_wvalid <= 1'b0;
            rwait       <= next_delay();
            wwait       <= next_delay();
        end else begin
            if (dmem_rvalid)
                dmem_rvalid <= 1'b0;
            else if (dmem_rready) begin
                if (rwait == 0) begin
                    dmem_rvalid <= 1'b1;
                    dmem_rdata  <= dmem[dmem_raddr[7:2]];
                    rwait       <= next_delay();
                end else
                    rwait <= rwait - 1;
            end
            if (dmem_wvalid)
                dmem_wvalid <= 1'b0;
            else if (dmem_wready) begin
                if (wwait == 0) begin
                    dmem_wvalid <= 1'b1;
                    dmem[dmem_waddr[7:2]] <= dmem_wdata;
                    check_store(dmem_waddr, dmem_wdata);
                    wwait <= next_delay();
                end else
                    wwait <= wwait - 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Sequencing
    task automatic apply_reset();
        @(posedge clk);
        resetb <= 1'b0;
        repeat (2) @(posedge clk);
        resetb <= 1'b1;
    endtask

    task automatic wait_stores();
        int cyc;
        cyc = 0;
        while (exp_addr.size() > 0 && cyc < 3000) begin
            @(posedge clk);
            cyc++;
        end
        if (exp_addr.size() > 0) begin
            $display("timeout, %0d expected stores never appeared", exp_addr.size());
            test_err++;
        end
        repeat (20) @(posedge clk);     // Catch late stray stores
    endtask

    task automatic check_exception();
        int cyc;
        cyc = 0;
        while (!exception && cyc < 200) begin
            @(posedge clk);
            cyc++;
        end
        if (!exception) begin
            $display("timeout, exception never went high");
            test_err++;
        end
        repeat (10) begin
            @(posedge clk);
            if (!exception) begin
                $display("exception fell at %0t", $time);
                test_err++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetb      = 1'b0;
        imem_valid  = 1'b1;
        imem_rdata  = 32'h0000_0013;
        dmem_rvalid = 1'b0;
        dmem_rdata  = '0;
        dmem_wvalid = 1'b0;
        lcg         = 32'h11bd_8929;
        n_pass      = 0;
        n_fail      = 0;
        for (int t = 1; t <= NTESTS; t++) begin
            test_err = 0;
            load_program(t);
            apply_reset();
            wait_stores();
            if (t >= 5)
                check_exception();
            else if (exception) begin
                $display("exception went high in test %0d", t);
                test_err++;
            end
            if (test_err == 0)
                n_pass++;
            else
                n_fail++;
            $display("test %0d: %s, %0d errors", t, test_err == 0 ? "ok" : "bad", test_err);
        end
        $display("tests ok %0d, bad %0d, assertion failures %0d",
                 n_pass, n_fail, u_dut.u_props.fail_cnt);
        if (n_fail == 0 && u_dut.u_props.fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sim/riscv_props.sv ====
//////////////////////////////////////////////////
// Port and handshake checks on riscv_core, bound in below
// Most checks are off while resetb is low
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

module riscv_props (
    input logic               clk,
    input logic               resetb,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic               dmem_rready,
    input logic [`RV_XLEN-1:0] dmem_raddr,
    input logic               dmem_rvalid,
    input logic               dmem_wready,
    input logic [`RV_XLEN-1:0] dmem_waddr,
    input logic [`RV_XLEN-1:0] dmem_wdata,
    input logic               dmem_wvalid,
    input logic               exception
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;

    // Requests held with stable address until valid
    a_rd_hold: assert property (@(posedge clk) disable iff (!resetb)
        dmem_rready && !dmem_rvalid |=> dmem_rready && $stable(dmem_raddr))
        else begin $error("load request dropped or moved before valid"); fail_cnt++; end
    a_wr_hold: assert property (@(posedge clk) disable iff (!resetb)
        dmem_wready && !dmem_wvalid |=>
        dmem_wready && $stable(dmem_waddr) && $stable(dmem_wdata))
        else begin $error("store request dropped or moved before valid"); fail_cnt++; end

    a_align: assert property (@(posedge clk) disable iff (!resetb)
        !exception |-> imem_addr[1:0] == 2'b00)
        else begin $error("misaligned fetch without exception"); fail_cnt++; end
    a_sticky: assert property (@(posedge clk) disable iff (!resetb) !$fell(exception))
        else begin $error("exception cleared without reset"); fail_cnt++; end
    a_reset_idle: assert property (@(posedge clk)
        $rose(resetb) |-> !dmem_rready && !dmem_wready)
        else begin $error("dmem request right after reset"); fail_cnt++; end

endmodule

bind riscv_core riscv_props u_props (
    .clk (clk), .resetb (resetb), .imem_addr (imem_addr),
    .dmem_rready (dmem_rready), .dmem_raddr (dmem_raddr),
    .dmem_rvalid (dmem_rvalid), .dmem_wready (dmem_wready), .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata), .dmem_wvalid (dmem_wvalid), .exception (exception)
);

// ==== design/riscv_core.sv ====
//////////////////////////////////////////////////
// imem word comes the cycle after an address taken with imem_ready, held while it is low
// dmem requests stay up with stable address until valid; word access only
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

module riscv_core import riscv_pkg::*; (
    input  logic  clk,
    input  logic  resetb,
    output word_t imem_addr,
    output logic  imem_ready,
    input  logic  imem_valid,
    input  word_t imem_rdata,
    output logic  dmem_rready,
    output word_t dmem_raddr,
    input  logic  dmem_rvalid,
    input  word_t dmem_rdata,
    output logic  dmem_wready,
    output word_t dmem_waddr,
    output word_t dmem_wdata,
    input  logic  dmem_wvalid,
    output logic  exception
);

    logic fault;

    dec_ex_if dx ();
    ex_wb_if  xw ();

    riscv_decode u_decode (
        .clk        (clk),
        .resetb     (resetb),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .fetch_pc   (imem_addr),
        .dx         (dx)
    );

    riscv_execute u_execute (
        .clk         (clk),
        .resetb      (resetb),
        .dx          (dx),
        .xw          (xw),
        .imem_valid  (imem_valid),
        .imem_addr   (imem_addr),
        .imem_ready  (imem_ready),
        .dmem_rready (dmem_rready),
        .dmem_raddr  (dmem_raddr),
        .dmem_rvalid (dmem_rvalid),
        .dmem_rdata  (dmem_rdata),
        .dmem_wready (dmem_wready),
        .dmem_waddr  (dmem_waddr),
        .dmem_wdata  (dmem_wdata),
        .dmem_wvalid (dmem_wvalid),
        .fault       (fault)
    );

    riscv_writeback u_writeback (
        .clk       (clk),
        .resetb    (resetb),
        .xw        (xw),
        .fault     (fault),
        .exception (exception)
    );

endmodule

// ==== design/riscv_writeback.sv ====
//////////////////////////////////////////////////
// Register file updates one edge after the result leaves execute
// Register contents are unknown after reset, x0 reads zero
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

module riscv_writeback import riscv_pkg::*; (
    input  logic        clk,
    input  logic        resetb,
    ex_wb_if.writeback  xw,
    input  logic        fault,
    output logic        exception
);

    word_t    regs [1:`RV_NREGS-1];
    logic     pend_valid;
    reg_idx_t pend_rd;
    word_t    pend_result;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            pend_valid <= 1'b0;
            exception  <= 1'b0;
        end else begin
            pend_valid <= xw.valid && xw.rd != '0;     // x0 writes dropped here
            if (fault)
                exception <= 1'b1;                     // Sticky
        end
    end

    always_ff @(posedge clk) begin
        pend_rd     <= xw.rd;
        pend_result <= xw.result;
        if (pend_valid)
            regs[pend_rd] <= pend_result;
    end

    //////////////////////////////////////////////////
    // Read ports with bypass of the pending result
    assign xw.rdata1 = (xw.rs1 == '0) ? '0 :
                       (pend_valid && pend_rd == xw.rs1) ? pend_result : regs[xw.rs1];
    assign xw.rdata2 = (xw.rs2 == '0) ? '0 :
                       (pend_valid && pend_rd == xw.rs2) ? pend_result : regs[xw.rs2];

endmodule

// ==== design/riscv_execute.sv ====
//////////////////////////////////////////////////
// Loads and stores hold the pipe until their valid; one of each in flight
// imem_ready drops while held so the fetch word stays put
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

module riscv_execute import riscv_pkg::*; (
    input  logic      clk,
    input  logic      resetb,
    dec_ex_if.execute dx,
    ex_wb_if.execute  xw,
    input  logic      imem_valid,
    output word_t     imem_addr,
    output logic      imem_ready,
    output logic      dmem_rready,
    output word_t     dmem_raddr,
    input  logic      dmem_rvalid,
    input  word_t     dmem_rdata,
    output logic      dmem_wready,
    output word_t     dmem_waddr,
    output word_t     dmem_wdata,
    input  logic      dmem_wvalid,
    output logic      fault
);

    word_t             op1;
    word_t             op2;
    word_t             eff_addr;    // rs1 + imm, loads, stores, JALR
    word_t             alu_res;
    word_t             result;
    word_t             target;
    word_t             fetch_pc;
    logic [`RV_XLEN:0] sub_s;
    logic [`RV_XLEN:0] sub_u;
    logic              br_cond;
    logic              taken;
    logic              writes;
    logic              ill_fn;
    logic              ld_done;
    logic              st_done;
    logic              hold;

    assign op1      = xw.rdata1;
    assign op2      = dx.imm_sel ? dx.imm : xw.rdata2;
    assign sub_s    = {op1[`RV_XLEN-1], op1} - {op2[`RV_XLEN-1], op2};
    assign sub_u    = {1'b0, op1} - {1'b0, op2};
    assign eff_addr = op1 + dx.imm;

    //////////////////////////////////////////////////
    // ALU and branch compare
    always_comb begin
        case (alu_fn_e'(dx.fn))
            ALU_ADD:  alu_res = dx.alt ? op1 - op2 : op1 + op2;
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SLT:  alu_res = {31'h0, sub_s[`RV_XLEN]};
            ALU_SLTU: alu_res = {31'h0, sub_u[`RV_XLEN]};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SR:   alu_res = dx.alt ? word_t'($signed(op1) >>> op2[4:0]) : op1 >> op2[4:0];
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
        endcase
        case (br_fn_e'(dx.fn))
            BR_BEQ:  br_cond = sub_u == '0;
            BR_BNE:  br_cond = sub_u != '0;
            BR_BLT:  br_cond = sub_s[`RV_XLEN];
            BR_BGE:  br_cond = !sub_s[`RV_XLEN];
            BR_BLTU: br_cond = sub_u[`RV_XLEN];
            BR_BGEU: br_cond = !sub_u[`RV_XLEN];
            default: br_cond = 1'b0;
        endcase
    end

    // alt only exists for SUB and SRA; funct3 010/011 are no branch
    assign ill_fn = (dx.kind == KIND_ALU && dx.alt && dx.fn != ALU_ADD && dx.fn != ALU_SR) ||
                    (dx.kind == KIND_BRANCH && dx.fn[2:1] == 2'b01);

    always_comb begin
        result = alu_res;
        target = dx.pc + dx.imm;
        writes = 1'b1;
        taken  = 1'b0;
        case (dx.kind)
            KIND_ALU:   ;
            KIND_LUI:   result = dx.imm;
            KIND_AUIPC: result = dx.pc + dx.imm;
            KIND_JAL: begin
                result = dx.pc + 32'd4;
                taken  = 1'b1;
            end
            KIND_JALR: begin
                result = dx.pc + 32'd4;
                target = {eff_addr[`RV_XLEN-1:1], 1'b0};
                taken  = 1'b1;
            end
            KIND_BRANCH: begin
                writes = 1'b0;
                taken  = br_cond;
            end
            KIND_LOAD:  result = dmem_rdata;    // Only used in the rvalid cycle
            default:    writes = 1'b0;          // None, store
        endcase
    end

    assign ld_done = dmem_rready && dmem_rvalid;
    assign st_done = dmem_wready && dmem_wvalid;
    assign hold    = (dx.kind == KIND_LOAD && !ld_done) || (dx.kind == KIND_STORE && !st_done);

    assign dx.hold  = hold;
    assign dx.flush = taken;
    assign xw.valid  = writes && !hold;
    assign xw.rd     = dx.rd;
    assign xw.result = result;
    assign xw.rs1    = dx.rs1;
    assign xw.rs2    = dx.rs2;

    assign fault = dx.illegal || ill_fn || (taken && target[1:0] != 2'b00);

    //////////////////////////////////////////////////
    // Fetch PC and memory requests
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb)
            fetch_pc <= `RV_RESETVEC;
        else if (taken)
            fetch_pc <= target;
        else if (!hold && imem_valid)
            fetch_pc <= fetch_pc + 32'd4;
    end

    assign imem_addr  = fetch_pc;
    assign imem_ready = !hold && imem_valid;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            dmem_rready <= 1'b0;
            dmem_wready <= 1'b0;
        end else begin
            if (ld_done)
                dmem_rready <= 1'b0;
            else if (dx.kind == KIND_LOAD)
                dmem_rready <= 1'b1;
            if (st_done)
                dmem_wready <= 1'b0;
            else if (dx.kind == KIND_STORE)
                dmem_wready <= 1'b1;
        end
    end

    // Address and data latched with the request, stable until valid
    always_ff @(posedge clk) begin
        if (dx.kind == KIND_LOAD && !dmem_rready)
            dmem_raddr <= eff_addr;
        if (dx.kind == KIND_STORE && !dmem_wready) begin
            dmem_waddr <= eff_addr;
            dmem_wdata <= xw.rdata2;
        end
    end

endmodule

// ==== design/riscv_decode.sv ====
//////////////////////////////////////////////////
// imem_rdata belongs to the address taken one cycle earlier
// First word after reset and two words after a flush are dropped
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

module riscv_decode import riscv_pkg::*; (
    input  logic     clk,
    input  logic     resetb,
    input  logic     imem_valid,
    input  word_t    imem_rdata,
    input  word_t    fetch_pc,
    dec_ex_if.decode dx
);

    word_t      inst;
    opcode_e    opc;
    logic [2:0] f3;
    word_t      imm;
    inst_kind_e kind;
    logic       illegal;
    logic       squash;     // Second slot after a flush still to drop
    logic       take;
    word_t      if_pc;      // Address of the word on imem_rdata

    assign take = !dx.hold && imem_valid;
    assign inst = (dx.flush || squash || !imem_valid) ? `RV_NOP : imem_rdata;
    assign opc  = opcode_e'(inst[6:0]);
    assign f3   = inst[14:12];

    always_comb begin
        case (opc)
            OPC_LUI, OPC_AUIPC: imm = {inst[31:12], 12'h0};
            OPC_JAL:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OPC_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_JALR, OPC_LOAD: imm = {{20{inst[31]}}, inst[31:20]};
            OPC_OP_IMM: imm = (f3 == ALU_SLL || f3 == ALU_SR) ?
                              {27'h0, inst[24:20]} : {{20{inst[31]}}, inst[31:20]};
            default:    imm = '0;
        endcase
    end

    always_comb begin
        kind    = KIND_NONE;
        illegal = 1'b0;
        case (opc)
            OPC_LUI:    kind = KIND_LUI;
            OPC_AUIPC:  kind = KIND_AUIPC;
            OPC_JAL:    kind = KIND_JAL;
            OPC_JALR:   kind = KIND_JALR;
            OPC_BRANCH: kind = KIND_BRANCH;
            OPC_LOAD:   kind = KIND_LOAD;
            OPC_STORE:  kind = KIND_STORE;
            OPC_OP_IMM: kind = KIND_ALU;
            OPC_OP:     kind = KIND_ALU;
            OPC_FENCE:  kind = KIND_NONE;   // No-op
            default:    illegal = 1'b1;     // SYSTEM lands here too
        endcase
        if (opc == OPC_OP && inst[31:25] != 7'h00 && inst[31:25] != 7'h20)
            illegal = 1'b1;
        if ((opc == OPC_LOAD || opc == OPC_STORE) && f3 != 3'b010)
            illegal = 1'b1;                 // Word access only
        if (illegal)
            kind = KIND_NONE;
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            squash     <= 1'b1;
            if_pc      <= `RV_RESETVEC;
            dx.kind    <= KIND_NONE;
            dx.illegal <= 1'b0;
        end else begin
            if (dx.flush)
                squash <= 1'b1;
            else if (take)
                squash <= 1'b0;
            if (take)
                if_pc  <= fetch_pc;
            if (!dx.hold) begin
                dx.kind    <= kind;
                dx.illegal <= illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!dx.hold) begin
            dx.fn      <= f3;
            dx.alt     <= inst[30] && (opc == OPC_OP ||
                          (opc == OPC_OP_IMM && (f3 == ALU_SLL || f3 == ALU_SR)));
            dx.imm_sel <= opc == OPC_OP_IMM || opc == OPC_LOAD || opc == OPC_JALR;
            dx.imm     <= imm;
            dx.rs1     <= inst[19:15];
            dx.rs2     <= inst[24:20];
            dx.rd      <= inst[11:7];
            dx.pc      <= if_pc;
        end
    end

endmodule

// ==== design/riscv_stage_if.sv ====
//////////////////////////////////////////////////
// Links between the three stages, point to point
//////////////////////////////////////////////////

// Decoded instruction forward, stall and flush back
interface dec_ex_if import riscv_pkg::*; ();
    inst_kind_e kind;
    logic [2:0] fn;         // funct3
    logic       alt;        // SUB or SRA
    logic       imm_sel;    // Operand 2 from imm
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      pc;
    logic       illegal;
    logic       hold;
    logic       flush;

    modport decode (
        output kind, fn, alt, imm_sel, imm, rs1, rs2, rd, pc, illegal,
        input  hold, flush
    );
    modport execute (
        input  kind, fn, alt, imm_sel, imm, rs1, rs2, rd, pc, illegal,
        output hold, flush
    );
endinterface

// Result forward, bypassed operands back
interface ex_wb_if import riscv_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    word_t    result;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rdata1;
    word_t    rdata2;

    modport execute   (output valid, rd, result, rs1, rs2, input rdata1, rdata2);
    modport writeback (input valid, rd, result, rs1, rs2, output rdata1, rdata2);
endinterface

// ==== design/riscv_pkg.sv ====
//////////////////////////////////////////////////
// Encodings and decoded-instruction types of the core
//////////////////////////////////////////////////
`include "riscv_cfg.svh"

package riscv_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SR, ALU_OR, ALU_AND
    } alu_fn_e;

    // 3'b010 and 3'b011 are not branches
    typedef enum logic [2:0] {
        BR_BEQ = 3'b000, BR_BNE = 3'b001, BR_BLT = 3'b100,
        BR_BGE = 3'b101, BR_BLTU = 3'b110, BR_BGEU = 3'b111
    } br_fn_e;

    typedef enum logic [3:0] {
        KIND_NONE, KIND_ALU, KIND_LUI, KIND_AUIPC, KIND_JAL,
        KIND_JALR, KIND_BRANCH, KIND_LOAD, KIND_STORE
    } inst_kind_e;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;

endpackage

// ==== design/riscv_cfg.svh ====
//////////////////////////////////////////////////
// Core build constants; RV32 only, so XLEN stays 32
//////////////////////////////////////////////////
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

`define RV_XLEN      32
`define RV_RESETVEC  32'h0000_0000

// ADDI x0,x0,0
`define RV_NOP       32'h0000_0013

`define RV_NREGS     32

`endif
